//--- rtl/fp_slice_pkg.sv
// --------------------
// Shared definitions for the two-lane FP slice
// Widths, vector types, encodings and the canonical NaN values
// used by the operand stage, the lanes and the result stage
// --------------------

`default_nettype none

package fp_slice_pkg;

  // Slice geometry
  localparam int unsigned WIDTH     = 32;
  localparam int unsigned NUM_LANES = 2;
  localparam int unsigned FP16_BITS = 16;

  // Bit position of the invalid flag in the status vector
  localparam int unsigned STATUS_NV = 4;

  typedef logic [WIDTH-1:0]     word_t;
  typedef logic [FP16_BITS-1:0] half_t;
  typedef logic [3:0]           tag_t;
  typedef logic [NUM_LANES-1:0] mask_t;

  // Order is NV, DZ, OF, UF, NX
  typedef logic [4:0] status_t;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fmt_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } op_e;

  // Rounding mode, reused as the operation modifier
  // SGNJ: RNE copies sign of b, RTZ inverts it, RDN xors both signs
  // MINMAX: RTZ selects max, anything else selects min
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // Canonical quiet NaNs
  localparam word_t CANON_NAN32 = 32'h7FC0_0000;
  localparam half_t CANON_NAN16 = 16'h7E00;

endpackage

`default_nettype wire

//--- rtl/lane_req_if.sv
// --------------------
// Request bundle from the operand stage to the lanes
// Lane 0 returns the ready for both lanes
// --------------------

`default_nettype none

interface lane_req_if;

  logic                        valid;
  logic                        ready;
  // Per-lane operands, lane 1 only uses the low half
  fp_slice_pkg::word_t         operand_a [fp_slice_pkg::NUM_LANES];
  fp_slice_pkg::word_t         operand_b [fp_slice_pkg::NUM_LANES];
  logic [fp_slice_pkg::NUM_LANES-1:0] lane_active;
  fp_slice_pkg::op_e           op;
  fp_slice_pkg::roundmode_e    rnd_mode;
  fp_slice_pkg::fmt_e          fmt;
  logic                        vectorial;
  fp_slice_pkg::mask_t         mask;
  fp_slice_pkg::tag_t          tag;

  modport src (
    output valid, operand_a, operand_b, lane_active, op, rnd_mode, fmt,
           vectorial, mask, tag,
    input  ready
  );

  modport lane (
    input  valid, operand_a, operand_b, lane_active, op, rnd_mode, fmt,
           vectorial, mask, tag,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/lane_rsp_if.sv
// --------------------
// Response bundle from the lanes to the result stage
// Lane 0 alone carries valid and the auxiliary data
// --------------------

`default_nettype none

interface lane_rsp_if;

  // One element per lane
  fp_slice_pkg::word_t result   [fp_slice_pkg::NUM_LANES];
  logic                nv       [fp_slice_pkg::NUM_LANES];
  logic                mask_bit [fp_slice_pkg::NUM_LANES];

  // Auxiliary data from lane 0
  logic                valid;
  fp_slice_pkg::fmt_e  fmt;
  logic                vectorial;
  fp_slice_pkg::tag_t  tag;

  logic                ready;

  modport lane (
    output result, nv, mask_bit, valid, fmt, vectorial, tag,
    input  ready
  );

  modport sink (
    input  result, nv, mask_bit, valid, fmt, vectorial, tag,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/slice_operand_stage.sv
// --------------------
// Operand register stage
// Slices both operands into per-lane words by format and
// decides which lanes take part in the operation
// --------------------

`default_nettype none

module slice_operand_stage (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     in_valid_i,
  input  logic                     flush_i,
  input  fp_slice_pkg::word_t      operand_a_i,
  input  fp_slice_pkg::word_t      operand_b_i,
  input  fp_slice_pkg::op_e        op_i,
  input  fp_slice_pkg::roundmode_e rnd_mode_i,
  input  fp_slice_pkg::fmt_e       fmt_i,
  input  logic                     vectorial_op_i,
  input  fp_slice_pkg::mask_t      simd_mask_i,
  input  fp_slice_pkg::tag_t       tag_i,
  output logic                     in_ready_o,
  lane_req_if.src                  req
);

  logic valid_q;
  logic vec_fp16;
  logic load;

  // Vector mode only exists for FP16, FP32 always runs scalar
  assign vec_fp16   = vectorial_op_i & (fmt_i == fp_slice_pkg::FP16);
  assign in_ready_o = req.ready | ~valid_q;
  assign load       = in_ready_o & in_valid_i;
  assign req.valid  = valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // --------------------
  // Lane slicing
  // --------------------
  always_ff @(posedge clk_i) begin
    if (load) begin
      if (fmt_i == fp_slice_pkg::FP32) begin
        req.operand_a[0] <= operand_a_i;
        req.operand_b[0] <= operand_b_i;
      end else begin
        req.operand_a[0] <= fp_slice_pkg::word_t'(operand_a_i[fp_slice_pkg::FP16_BITS-1:0]);
        req.operand_b[0] <= fp_slice_pkg::word_t'(operand_b_i[fp_slice_pkg::FP16_BITS-1:0]);
      end
      // Upper FP16 element always goes to lane 1
      req.operand_a[1] <= fp_slice_pkg::word_t'(operand_a_i[fp_slice_pkg::WIDTH-1 -:
                                                            fp_slice_pkg::FP16_BITS]);
      req.operand_b[1] <= fp_slice_pkg::word_t'(operand_b_i[fp_slice_pkg::WIDTH-1 -:
                                                            fp_slice_pkg::FP16_BITS]);
      req.lane_active  <= {vec_fp16, 1'b1};
      req.op           <= op_i;
      req.rnd_mode     <= rnd_mode_i;
      req.fmt          <= fmt_i;
      req.vectorial    <= vec_fp16;
      req.mask         <= simd_mask_i;
      req.tag          <= tag_i;
    end
  end

  // Upstream keeps its request up until it is taken
  a_in_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i && !in_ready_o && !flush_i |=> in_valid_i);

endmodule

`default_nettype wire

//--- rtl/sgnj_minmax_lane.sv
// --------------------
// One SIMD lane of the non-computational group
// Sign injection and min/max in FP32 or FP16, one register stage
// Lane 0 carries the handshake and the auxiliary data
// --------------------

`default_nettype none

module sgnj_minmax_lane #(
  parameter int unsigned Lane = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      flush_i,
  lane_req_if.lane  req,
  lane_rsp_if.lane  rsp
);

  // Returns {is_nan, is_snan} for a value left-aligned in 32 bits
  function automatic logic [1:0] nan_class(input fp_slice_pkg::word_t n, input logic half);
    logic nan;
    logic quiet;
    if (half) begin
      nan   = (n[30:26] == 5'h1F) && (n[25:16] != '0);
      quiet = n[25];
    end else begin
      nan   = (n[30:23] == 8'hFF) && (n[22:0] != '0);
      quiet = n[22];
    end
    return {nan, nan & ~quiet};
  endfunction

  logic                is_half;
  fp_slice_pkg::half_t a_h;
  fp_slice_pkg::half_t b_h;
  fp_slice_pkg::word_t a_n;
  fp_slice_pkg::word_t b_n;
  fp_slice_pkg::word_t canon_n;
  fp_slice_pkg::word_t res_n;
  fp_slice_pkg::word_t res_d;
  fp_slice_pkg::word_t result_q;
  logic [1:0]          a_cls;
  logic [1:0]          b_cls;
  logic                a_lt_b;
  logic                sign_res;
  logic                nv_d;
  logic                nv_q;
  logic                mask_q;
  logic                load;

  assign is_half = (Lane == 1) || (req.fmt == fp_slice_pkg::FP16);
  assign a_h     = req.operand_a[Lane][fp_slice_pkg::FP16_BITS-1:0];
  assign b_h     = req.operand_b[Lane][fp_slice_pkg::FP16_BITS-1:0];

  // FP16 is moved to the top so both formats share sign and ordering logic
  assign a_n     = is_half ? {a_h, {fp_slice_pkg::FP16_BITS{1'b0}}} : req.operand_a[Lane];
  assign b_n     = is_half ? {b_h, {fp_slice_pkg::FP16_BITS{1'b0}}} : req.operand_b[Lane];
  assign canon_n = is_half ? {fp_slice_pkg::CANON_NAN16, {fp_slice_pkg::FP16_BITS{1'b0}}}
                           : fp_slice_pkg::CANON_NAN32;
  assign a_cls   = nan_class(a_n, is_half);
  assign b_cls   = nan_class(b_n, is_half);

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin
    if (a_n[31] != b_n[31]) begin
      a_lt_b = a_n[31];
    end else if (a_n[31]) begin
      a_lt_b = a_n[30:0] > b_n[30:0];
    end else begin
      a_lt_b = a_n[30:0] < b_n[30:0];
    end
  end

  always_comb begin
    case (req.rnd_mode)
      fp_slice_pkg::RTZ: sign_res = ~b_n[31];
      fp_slice_pkg::RDN: sign_res = a_n[31] ^ b_n[31];
      default:           sign_res = b_n[31];
    endcase
  end

  // --------------------
  // Operation select
  // --------------------
  always_comb begin
    nv_d  = 1'b0;
    res_n = a_n;
    case (req.op)
      fp_slice_pkg::SGNJ: begin
        res_n = {sign_res, a_n[30:0]};
      end
      fp_slice_pkg::MINMAX: begin
        nv_d = a_cls[0] | b_cls[0];
        if (a_cls[1] && b_cls[1]) begin
          res_n = canon_n;
        end else if (a_cls[1]) begin
          res_n = b_n;
        end else if (b_cls[1]) begin
          res_n = a_n;
        end else if (req.rnd_mode == fp_slice_pkg::RTZ) begin
          res_n = a_lt_b ? b_n : a_n;
        end else begin
          res_n = a_lt_b ? a_n : b_n;
        end
      end
    endcase
  end

  // Back to the lane's own alignment
  assign res_d = is_half ? fp_slice_pkg::word_t'(res_n[31 -: fp_slice_pkg::FP16_BITS]) : res_n;
  assign load  = req.valid & req.ready;

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q <= res_d;
      nv_q     <= nv_d & req.lane_active[Lane];
      mask_q   <= req.mask[Lane];
    end
  end

  assign rsp.result[Lane]   = result_q;
  assign rsp.nv[Lane]       = nv_q;
  assign rsp.mask_bit[Lane] = mask_q;

  if (Lane == 0) begin : g_ctrl
    logic               valid_q;
    fp_slice_pkg::fmt_e fmt_q;
    logic               vec_q;
    fp_slice_pkg::tag_t tag_q;

    assign req.ready = rsp.ready | ~valid_q;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;
      end else if (req.ready) begin
        valid_q <= req.valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        fmt_q <= req.fmt;
        vec_q <= req.vectorial;
        tag_q <= req.tag;
      end
    end

    assign rsp.valid     = valid_q;
    assign rsp.fmt       = fmt_q;
    assign rsp.vectorial = vec_q;
    assign rsp.tag       = tag_q;
  end else begin : g_upper
    // Upper lane only ever runs for vector FP16
    a_upper_fp16: assert property (@(posedge clk_i) disable iff (reset_i)
      req.valid && req.lane_active[Lane] |->
        (req.fmt == fp_slice_pkg::FP16) && req.vectorial);
  end

endmodule

`default_nettype wire

//--- rtl/slice_result_stage.sv
// --------------------
// Result register stage
// Packs lane results by format, NaN-boxes scalar FP16
// and folds the masked lane flags into one status
// --------------------

`default_nettype none

module slice_result_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  out_ready_i,
  lane_rsp_if.sink              rsp,
  output fp_slice_pkg::word_t   result_o,
  output fp_slice_pkg::status_t status_o,
  output fp_slice_pkg::tag_t    tag_o,
  output logic                  out_valid_o
);

  fp_slice_pkg::half_t   lo_h;
  fp_slice_pkg::half_t   hi_h;
  fp_slice_pkg::word_t   packed_d;
  fp_slice_pkg::status_t status_d;
  logic                  nv_any;

  assign rsp.ready = out_ready_i | ~out_valid_o;
  assign lo_h      = rsp.result[0][fp_slice_pkg::FP16_BITS-1:0];
  assign hi_h      = rsp.result[1][fp_slice_pkg::FP16_BITS-1:0];

  always_comb begin
    if (rsp.fmt == fp_slice_pkg::FP32) begin
      packed_d = rsp.result[0];
    end else if (rsp.vectorial) begin
      packed_d = {hi_h, lo_h};
    end else begin
      // Scalar FP16 NaN-boxed
      packed_d = {{fp_slice_pkg::FP16_BITS{1'b1}}, lo_h};
    end
  end

  // Lanes with a cleared mask bit do not report
  always_comb begin
    nv_any   = 1'b0;
    status_d = '0;
    for (int i = 0; i < int'(fp_slice_pkg::NUM_LANES); i++) begin
      nv_any = nv_any | (rsp.nv[i] & rsp.mask_bit[i]);
    end
    status_d[fp_slice_pkg::STATUS_NV] = nv_any;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      out_valid_o <= 1'b0;
    end else if (rsp.ready) begin
      out_valid_o <= rsp.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp.ready && rsp.valid) begin
      result_o <= packed_d;
      status_o <= status_d;
      tag_o    <= rsp.tag;
    end
  end

  // Output holds while the consumer stalls
  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i && !flush_i |=> $stable(out_valid_o) && $stable(result_o));

endmodule

`default_nettype wire

//--- rtl/fp_slice_top.sv
// --------------------
// Two-lane multi-format FP slice, SGNJ and MINMAX
// Operand stage, two lanes and result stage, three cycles deep
// --------------------

`default_nettype none

module fp_slice_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     in_valid_i,
  input  logic                     out_ready_i,
  input  logic                     flush_i,
  input  fp_slice_pkg::word_t      operand_a_i,
  input  fp_slice_pkg::word_t      operand_b_i,
  input  fp_slice_pkg::op_e        op_i,
  input  fp_slice_pkg::roundmode_e rnd_mode_i,
  input  fp_slice_pkg::fmt_e       fmt_i,
  input  logic                     vectorial_op_i,
  input  fp_slice_pkg::mask_t      simd_mask_i,
  input  fp_slice_pkg::tag_t       tag_i,
  output logic                     in_ready_o,
  output fp_slice_pkg::word_t      result_o,
  output fp_slice_pkg::status_t    status_o,
  output fp_slice_pkg::tag_t       tag_o,
  output logic                     out_valid_o
);

  lane_req_if req_if ();
  lane_rsp_if rsp_if ();

  slice_operand_stage u_operand_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .in_valid_i     (in_valid_i),
    .flush_i        (flush_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .op_i           (op_i),
    .rnd_mode_i     (rnd_mode_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .tag_i          (tag_i),
    .in_ready_o     (in_ready_o),
    .req            (req_if.src)
  );

  // Lane 0 owns the handshake, lane 1 follows in lockstep
  for (genvar i = 0; i < int'(fp_slice_pkg::NUM_LANES); i++) begin : g_lane
    sgnj_minmax_lane #(
      .Lane (i)
    ) u_lane (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .flush_i (flush_i),
      .req     (req_if.lane),
      .rsp     (rsp_if.lane)
    );
  end

  slice_result_stage u_result_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .rsp         (rsp_if.sink),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_ref_model.svh
// --------------------
// Reference model for the FP slice testbench
// Expected result and status for one request, built from the
// SGNJ and MINMAX rules on FP32 and FP16 elements
// --------------------

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`default_nettype none

typedef struct packed {
  fp_slice_pkg::word_t      a;
  fp_slice_pkg::word_t      b;
  fp_slice_pkg::op_e        op;
  fp_slice_pkg::roundmode_e rm;
  fp_slice_pkg::fmt_e       fmt;
  logic                     vec;
  fp_slice_pkg::mask_t      mask;
  fp_slice_pkg::tag_t       tag;
} req_t;

typedef struct packed {
  fp_slice_pkg::word_t   result;
  fp_slice_pkg::status_t status;
  fp_slice_pkg::tag_t    tag;
} exp_t;

function automatic logic is_nan(input logic [31:0] x, input logic half);
  if (half) begin
    return (x[14:10] == 5'h1F) && (x[9:0] != 10'h0);
  end
  return (x[30:23] == 8'hFF) && (x[22:0] != 23'h0);
endfunction

// Signalling NaN has the top mantissa bit clear
function automatic logic is_snan(input logic [31:0] x, input logic half);
  return is_nan(x, half) && !(half ? x[9] : x[22]);
endfunction

// Unsigned key in value order, so -0 sorts below +0
function automatic logic [31:0] order_key(input logic [31:0] x, input int unsigned bits);
  logic [31:0] top;
  logic [31:0] all;
  top = 32'h1 << (bits - 1);
  all = (top << 1) - 32'h1;
  return ((x & top) != 32'h0) ? (~x & all) : (x | top);
endfunction

// One element, FP16 values sit zero-extended in the low half
function automatic logic [31:0] ref_element(input logic [31:0] x, input logic [31:0] y,
                                            input fp_slice_pkg::op_e op,
                                            input fp_slice_pkg::roundmode_e rm,
                                            input logic half, output logic nv);
  int unsigned sb;
  logic [31:0] r;
  logic        x_ge_y;
  sb = half ? 15 : 31;
  nv = 1'b0;
  r  = x;
  if (op == fp_slice_pkg::SGNJ) begin
    case (rm)
      fp_slice_pkg::RTZ: r[sb] = ~y[sb];
      fp_slice_pkg::RDN: r[sb] = x[sb] ^ y[sb];
      default:           r[sb] = y[sb];
    endcase
  end else begin
    nv = is_snan(x, half) || is_snan(y, half);
    if (is_nan(x, half) && is_nan(y, half)) begin
      r = half ? 32'(fp_slice_pkg::CANON_NAN16) : fp_slice_pkg::CANON_NAN32;
    end else if (is_nan(x, half)) begin
      r = y;
    end else if (is_nan(y, half)) begin
      r = x;
    end else begin
      x_ge_y = order_key(x, sb + 1) >= order_key(y, sb + 1);
      if (rm == fp_slice_pkg::RTZ) begin
        r = x_ge_y ? x : y;
      end else begin
        r = x_ge_y ? y : x;
      end
    end
  end
  return r;
endfunction

function automatic exp_t ref_model(input req_t q);
  exp_t        e;
  logic        nv_lo;
  logic        nv_hi;
  logic [31:0] lo;
  logic [31:0] hi;
  e.tag    = q.tag;
  e.status = '0;
  nv_hi    = 1'b0;
  if (q.fmt == fp_slice_pkg::FP32) begin
    // Vector flag has no meaning for FP32
    e.result = ref_element(q.a, q.b, q.op, q.rm, 1'b0, nv_lo);
  end else begin
    lo = ref_element(32'(q.a[15:0]), 32'(q.b[15:0]), q.op, q.rm, 1'b1, nv_lo);
    hi = ref_element(32'(q.a[31:16]), 32'(q.b[31:16]), q.op, q.rm, 1'b1, nv_hi);
    if (q.vec) begin
      e.result = {hi[15:0], lo[15:0]};
    end else begin
      e.result = {16'hFFFF, lo[15:0]};
      nv_hi    = 1'b0;
    end
  end
  e.status[fp_slice_pkg::STATUS_NV] = (nv_lo & q.mask[0]) | (nv_hi & q.mask[1]);
  return e;
endfunction

`default_nettype wire

`endif

//--- testbench/tb_fp_slice.sv
// --------------------
// Testbench for the two-lane FP slice
// Random and directed SGNJ/MINMAX traffic against a scoreboard,
// with back-pressure, flush and a watchdog
// --------------------

`include "tb_ref_model.svh"

`default_nettype none

module tb_fp_slice #(
  parameter int unsigned SEED = 49
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD      = 4;
  localparam int unsigned RESET_CYCLES    = 16;
  localparam int unsigned N_FP32          = 300;
  localparam int unsigned N_VEC16         = 100;
  localparam int unsigned N_HALF          = 40;
  localparam int unsigned N_VEC32         = 20;
  localparam int unsigned N_PAIRS         = 9;
  localparam int unsigned N_DIRECTED      = N_PAIRS * 5;
  localparam int unsigned N_FLUSH         = 13;
  localparam int unsigned TOTAL_ITEMS     = N_FP32 + N_VEC16 + N_HALF + N_VEC32
                                            + N_DIRECTED + N_FLUSH;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_ITEMS * 20 + RESET_CYCLES;

  // Consumer behavior
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  // Special values: qNaN, one, sNaN, zeros, minus two
  localparam fp_slice_pkg::word_t DIR_A [N_PAIRS] = '{
    32'h7FC0_0001, 32'h3F80_0000, 32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000,
    32'hFF80_0005, 32'h8000_0000, 32'h0000_0000, 32'h3F80_0000};
  localparam fp_slice_pkg::word_t DIR_B [N_PAIRS] = '{
    32'h3F80_0000, 32'h7FC0_0001, 32'h3F80_0000, 32'h7F80_0001, 32'h7F80_0001,
    32'h7FA0_0000, 32'h0000_0000, 32'h8000_0000, 32'hC000_0000};

  logic                     clk_i;
  logic                     reset_i;
  logic                     in_valid_i;
  logic                     out_ready_i = 1'b1;
  logic                     flush_i;
  fp_slice_pkg::word_t      operand_a_i;
  fp_slice_pkg::word_t      operand_b_i;
  fp_slice_pkg::op_e        op_i;
  fp_slice_pkg::roundmode_e rnd_mode_i;
  fp_slice_pkg::fmt_e       fmt_i;
  logic                     vectorial_op_i;
  fp_slice_pkg::mask_t      simd_mask_i;
  fp_slice_pkg::tag_t       tag_i;
  logic                     in_ready_o;
  fp_slice_pkg::word_t      result_o;
  fp_slice_pkg::status_t    status_o;
  fp_slice_pkg::tag_t       tag_o;
  logic                     out_valid_o;

  exp_t        exp_q [$];
  int unsigned errors    = 0;
  int unsigned n_sent    = 0;
  int unsigned n_checked = 0;
  int unsigned n_flushed = 0;
  int          ready_mode = READY_HIGH;
  logic [31:0] ready_rnd;

  fp_slice_top dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .in_valid_i     (in_valid_i),
    .out_ready_i    (out_ready_i),
    .flush_i        (flush_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .op_i           (op_i),
    .rnd_mode_i     (rnd_mode_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .tag_i          (tag_i),
    .in_ready_o     (in_ready_o),
    .result_o       (result_o),
    .status_o       (status_o),
    .tag_o          (tag_o),
    .out_valid_o    (out_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  function automatic fp_slice_pkg::word_t rand_single();
    logic [31:0] r;
    logic [31:0] sel;
    r   = $urandom;
    sel = $urandom % 8;
    case (sel)
      0:       return {r[31], 8'hFF, 1'b1, r[21:0]};
      1:       return {r[31], 8'hFF, 1'b0, r[21:1], 1'b1};
      2:       return {r[31], 31'h0};
      3:       return {r[31], 8'h3F, r[22:0]};
      default: return r;
    endcase
  endfunction

  function automatic fp_slice_pkg::half_t rand_half();
    logic [31:0] r;
    logic [31:0] sel;
    r   = $urandom;
    sel = $urandom % 8;
    case (sel)
      0:       return {r[15], 5'h1F, 1'b1, r[8:0]};
      1:       return {r[15], 5'h1F, 1'b0, r[8:1], 1'b1};
      2:       return {r[15], 15'h0};
      3:       return {r[15], 5'h0F, r[9:0]};
      default: return r[15:0];
    endcase
  endfunction

  function automatic req_t rand_req(input fp_slice_pkg::fmt_e fmt, input logic vec);
    req_t        q;
    logic [31:0] r;
    r      = $urandom;
    q.fmt  = fmt;
    q.vec  = vec;
    q.op   = fp_slice_pkg::op_e'(r[0]);
    q.rm   = fp_slice_pkg::roundmode_e'(3'($urandom_range(4, 0)));
    q.mask = r[9:8];
    q.tag  = r[13:10];
    if (fmt == fp_slice_pkg::FP32) begin
      q.a = rand_single();
      q.b = rand_single();
    end else begin
      q.a = {rand_half(), rand_half()};
      q.b = {rand_half(), rand_half()};
    end
    return q;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_item(input req_t q);
    operand_a_i    = q.a;
    operand_b_i    = q.b;
    op_i           = q.op;
    rnd_mode_i     = q.rm;
    fmt_i          = q.fmt;
    vectorial_op_i = q.vec;
    simd_mask_i    = q.mask;
    tag_i          = q.tag;
    in_valid_i     = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!in_ready_o);
    @(negedge clk_i);
  endtask

  task automatic go_idle();
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain(input int unsigned max_cycles);
    int unsigned n;
    n          = 0;
    ready_mode = READY_HIGH;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d expected result(s) never came out", exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
  endtask

  task automatic finish_test(input int num, input string name, input int unsigned errs_before);
    $display("Test %0d (%s) finished with %0d error(s)", num, name, errors - errs_before);
  endtask

  // Consumer side ready
  always @(negedge clk_i) begin
    ready_rnd = $urandom;
    case (ready_mode)
      READY_RANDOM: out_ready_i = ready_rnd[0];
      READY_LOW:    out_ready_i = 1'b0;
      default:      out_ready_i = 1'b1;
    endcase
  end

  // --------------------
  // Scoreboard
  // --------------------
  always @(posedge clk_i) begin
    exp_t e;
    req_t cur;
    if (!reset_i) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: output with tag %h arrived while no result was expected", tag_o);
          errors++;
        end else begin
          e = exp_q.pop_front();
          compare_value("result_o", result_o, e.result);
          compare_value("status_o", 32'(status_o), 32'(e.status));
          compare_value("tag_o", 32'(tag_o), 32'(e.tag));
          n_checked++;
        end
      end
      if (flush_i) begin
        // Everything in flight is discarded
        n_flushed += exp_q.size();
        exp_q.delete();
      end else if (in_valid_i && in_ready_o) begin
        cur.a    = operand_a_i;
        cur.b    = operand_b_i;
        cur.op   = op_i;
        cur.rm   = rnd_mode_i;
        cur.fmt  = fmt_i;
        cur.vec  = vectorial_op_i;
        cur.mask = simd_mask_i;
        cur.tag  = tag_i;
        exp_q.push_back(ref_model(cur));
        n_sent++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
             WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int unsigned errs_before;
    req_t        q;
    void'($urandom(SEED));
    reset_i        = 1'b1;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fp_slice_pkg::SGNJ;
    rnd_mode_i     = fp_slice_pkg::RNE;
    fmt_i          = fp_slice_pkg::FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    errs_before = errors;
    compare_value("out_valid_o", 32'(out_valid_o), 32'h0);
    compare_value("in_ready_o", 32'(in_ready_o), 32'h1);
    finish_test(1, "state after reset", errs_before);

    errs_before = errors;
    ready_mode  = READY_RANDOM;
    for (int i = 0; i < int'(N_FP32); i++) begin
      send_item(rand_req(fp_slice_pkg::FP32, 1'b0));
    end
    go_idle();
    wait_drain(100);
    finish_test(2, "random scalar FP32", errs_before);

    errs_before = errors;
    ready_mode  = READY_RANDOM;
    for (int i = 0; i < int'(N_VEC16); i++) begin
      send_item(rand_req(fp_slice_pkg::FP16, 1'b1));
    end
    go_idle();
    wait_drain(100);
    finish_test(3, "random vector FP16", errs_before);

    errs_before = errors;
    for (int i = 0; i < int'(N_HALF); i++) begin
      send_item(rand_req(fp_slice_pkg::FP16, 1'b0));
    end
    // FP32 with the vector flag set
    for (int i = 0; i < int'(N_VEC32); i++) begin
      send_item(rand_req(fp_slice_pkg::FP32, 1'b1));
    end
    go_idle();
    wait_drain(100);
    finish_test(4, "scalar FP16 boxing and vector FP32", errs_before);

    errs_before = errors;
    for (int i = 0; i < int'(N_PAIRS); i++) begin
      for (int m = 0; m < 5; m++) begin
        q.a    = DIR_A[i];
        q.b    = DIR_B[i];
        q.op   = (m < 2) ? fp_slice_pkg::MINMAX : fp_slice_pkg::SGNJ;
        q.rm   = fp_slice_pkg::roundmode_e'(3'((m < 2) ? m : m - 2));
        q.fmt  = fp_slice_pkg::FP32;
        q.vec  = 1'b0;
        q.mask = 2'b01;
        q.tag  = 4'(i + m);
        send_item(q);
      end
    end
    go_idle();
    wait_drain(100);
    finish_test(5, "directed special values", errs_before);

    errs_before = errors;
    ready_mode  = READY_LOW;
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < 3; i++) begin
      send_item(rand_req(fp_slice_pkg::FP32, 1'b0));
    end
    go_idle();
    compare_value("in_ready_o", 32'(in_ready_o), 32'h0);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    // Every stage is empty right after the flush
    compare_value("out_valid_o", 32'(out_valid_o), 32'h0);
    compare_value("in_ready_o", 32'(in_ready_o), 32'h1);
    ready_mode = READY_HIGH;
    repeat (6) @(negedge clk_i);
    ready_mode = READY_RANDOM;
    for (int i = 0; i < int'(N_FLUSH) - 3; i++) begin
      send_item(rand_req(fp_slice_pkg::FP16, 1'b1));
    end
    go_idle();
    wait_drain(100);
    repeat (5) @(negedge clk_i);
    finish_test(6, "back-pressure and flush", errs_before);

    $display("Counts: %0d accepted, %0d checked, %0d flushed, %0d errors",
             n_sent, n_checked, n_flushed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+testbench
rtl/fp_slice_pkg.sv
rtl/lane_req_if.sv
rtl/lane_rsp_if.sv
rtl/slice_operand_stage.sv
rtl/sgnj_minmax_lane.sv
rtl/slice_result_stage.sv
rtl/fp_slice_top.sv
testbench/tb_fp_slice.sv

//--- Makefile
# Verilator simulation of the two-lane FP slice

VERILATOR ?= verilator
TOP       ?= tb_fp_slice
SEED      ?= 49
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP SEED FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
